/* source/mips_id_pkg.sv */
`default_nettype none

package mips_id_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_idx_t;

	localparam reg_idx_t LINK_REG = 5'd31;

	////////////////////////////////////////////////////////////
	// Instruction formats
	typedef struct packed {
		logic [5:0] op;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm16;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target26;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} inst_u;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a
	} funct_e;

	////////////////////////////////////////////////////////////
	// Operations for EX
	typedef enum logic [7:0] {
		ALU_NOP  = 8'b0000_0000,
		ALU_OR   = 8'b0010_0101,
		ALU_AND  = 8'b0010_0100,
		ALU_XOR  = 8'b0010_0110,
		ALU_NOR  = 8'b0010_0111,
		ALU_ADDU = 8'b0010_0001,
		ALU_SUBU = 8'b0010_0011,
		ALU_SLT  = 8'b0010_1010,
		ALU_LW   = 8'b1110_0011,
		ALU_SW   = 8'b1110_1011,
		ALU_J    = 8'b0100_1111,
		ALU_JAL  = 8'b0101_0000,
		ALU_JR   = 8'b0000_1000,
		ALU_BEQ  = 8'b0101_0001,
		ALU_BNE  = 8'b0101_0010
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alu_sel_e;

	typedef enum logic [1:0] {
		BR_NONE = 2'd0,
		BR_JUMP = 2'd1,
		BR_EQ   = 2'd2,
		BR_NE   = 2'd3
	} br_kind_e;

	////////////////////////////////////////////////////////////
	// Stage bundles
	typedef struct packed {
		word_t pc;
		inst_u inst;
	} fetch_t;

	typedef struct packed {
		alu_op_e  aluop;
		alu_sel_e alusel;
		reg_idx_t rs;
		reg_idx_t rt;
		logic     rs_en;
		logic     rt_en;
		reg_idx_t wd;
		logic     wreg;
		word_t    imm;
		br_kind_e br_kind;
		logic     link;
	} dec_ctrl_t;

	typedef struct packed {
		logic     wreg;
		logic     is_load;
		reg_idx_t wd;
		word_t    wdata;
	} ex_bypass_t;

	typedef struct packed {
		logic     wreg;
		reg_idx_t wd;
		word_t    wdata;
	} mem_bypass_t;

	typedef struct packed {
		logic     we;
		reg_idx_t waddr;
		word_t    wdata;
	} wb_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		alu_op_e  aluop;
		alu_sel_e alusel;
		word_t    reg1;
		word_t    reg2;
		reg_idx_t wd;
		logic     wreg;
		word_t    link_addr;
		word_t    mem_offset;
	} id_ex_t;

endpackage

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  mips_id_pkg::wb_t     wb_i,
	input  mips_id_pkg::reg_idx_t raddr1_i,
	input  mips_id_pkg::reg_idx_t raddr2_i,
	output mips_id_pkg::word_t   rdata1_o,
	output mips_id_pkg::word_t   rdata2_o
);
	import mips_id_pkg::*;

	// r0 is hardwired, no storage
	word_t regs [1:31];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.we && wb_i.waddr != 5'd0) begin
			regs[wb_i.waddr] <= wb_i.wdata;
		end
	end

	function automatic word_t read_port(input reg_idx_t idx);
		word_t data;
		if (idx == 5'd0) begin
			data = '0;
		end else if (wb_i.we && wb_i.waddr == idx) begin
			// Write-through
			data = wb_i.wdata;
		end else begin
			data = regs[idx];
		end
		return data;
	endfunction

	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

	// A write to r0 leaves every stored value alone
	a_r0_write_ignored: assert property (@(posedge clk_i) disable iff (rst_i)
		(wb_i.we && wb_i.waddr == 5'd0) |=>
			(!$stable(raddr1_i) || (wb_i.we && wb_i.waddr == raddr1_i) || $stable(rdata1_o)));

endmodule

`default_nettype wire

/* source/inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
	input  mips_id_pkg::inst_u     inst_i,
	input  mips_id_pkg::word_t     pc_i,
	output mips_id_pkg::dec_ctrl_t ctrl_o
);
	import mips_id_pkg::*;

	word_t    pc_plus4;
	word_t    imm_zext;
	word_t    imm_sext;
	word_t    jump_target;
	logic     r_known;
	alu_op_e  r_op;
	alu_sel_e r_sel;
	logic     i_known;
	alu_op_e  i_op;
	alu_sel_e i_sel;
	word_t    i_imm;

	assign pc_plus4    = pc_i + 32'd4;
	assign imm_zext    = {16'h0000, inst_i.i.imm16};
	assign imm_sext    = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
	// Stays in the 256MB region of the delay slot
	assign jump_target = {pc_plus4[31:28], inst_i.j.target26, 2'b00};

	////////////////////////////////////////////////////////////
	// SPECIAL function field
	always_comb begin
		r_known = (inst_i.r.shamt == 5'd0);
		r_sel   = SEL_LOGIC;
		case (inst_i.r.funct)
			FN_OR:   r_op = ALU_OR;
			FN_AND:  r_op = ALU_AND;
			FN_XOR:  r_op = ALU_XOR;
			FN_NOR:  r_op = ALU_NOR;
			FN_ADDU: begin
				r_op  = ALU_ADDU;
				r_sel = SEL_ARITH;
			end
			FN_SUBU: begin
				r_op  = ALU_SUBU;
				r_sel = SEL_ARITH;
			end
			FN_SLT: begin
				r_op  = ALU_SLT;
				r_sel = SEL_ARITH;
			end
			FN_JR: begin
				r_op  = ALU_JR;
				r_sel = SEL_JUMP_BRANCH;
			end
			default: begin
				r_op    = ALU_NOP;
				r_sel   = SEL_NOP;
				r_known = 1'b0;
			end
		endcase
	end

	// Immediate ALU forms
	always_comb begin
		i_known = 1'b1;
		i_sel   = SEL_LOGIC;
		i_imm   = imm_zext;
		case (inst_i.i.op)
			OP_ORI:  i_op = ALU_OR;
			OP_ANDI: i_op = ALU_AND;
			OP_XORI: i_op = ALU_XOR;
			OP_LUI: begin
				i_op  = ALU_OR;
				i_imm = {inst_i.i.imm16, 16'h0000};
			end
			OP_ADDIU: begin
				i_op  = ALU_ADDU;
				i_sel = SEL_ARITH;
				i_imm = imm_sext;
			end
			OP_SLTI: begin
				i_op  = ALU_SLT;
				i_sel = SEL_ARITH;
				i_imm = imm_sext;
			end
			default: begin
				i_op    = ALU_NOP;
				i_known = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////
	// Control bundle, NOP unless decoded below
	always_comb begin
		ctrl_o    = '0;
		ctrl_o.rs = inst_i.i.rs;
		ctrl_o.rt = inst_i.i.rt;
		ctrl_o.wd = inst_i.r.rd;
		case (inst_i.i.op)
			OP_SPECIAL: begin
				if (r_known) begin
					ctrl_o.aluop  = r_op;
					ctrl_o.alusel = r_sel;
					ctrl_o.rs_en  = 1'b1;
					if (r_op == ALU_JR) begin
						ctrl_o.br_kind = BR_JUMP;
					end else begin
						ctrl_o.rt_en = 1'b1;
						ctrl_o.wreg  = 1'b1;
					end
				end
			end
			OP_J, OP_JAL: begin
				ctrl_o.aluop   = (inst_i.j.op == OP_JAL) ? ALU_JAL : ALU_J;
				ctrl_o.alusel  = SEL_JUMP_BRANCH;
				ctrl_o.br_kind = BR_JUMP;
				ctrl_o.imm     = jump_target;
				ctrl_o.link    = (inst_i.j.op == OP_JAL);
				ctrl_o.wreg    = (inst_i.j.op == OP_JAL);
				ctrl_o.wd      = LINK_REG;
			end
			OP_BEQ, OP_BNE: begin
				ctrl_o.aluop   = (inst_i.i.op == OP_BEQ) ? ALU_BEQ : ALU_BNE;
				ctrl_o.br_kind = (inst_i.i.op == OP_BEQ) ? BR_EQ : BR_NE;
				ctrl_o.alusel  = SEL_JUMP_BRANCH;
				ctrl_o.rs_en   = 1'b1;
				ctrl_o.rt_en   = 1'b1;
				ctrl_o.imm     = imm_sext;
			end
			OP_LW, OP_SW: begin
				ctrl_o.aluop  = (inst_i.i.op == OP_LW) ? ALU_LW : ALU_SW;
				ctrl_o.alusel = SEL_LOAD_STORE;
				ctrl_o.rs_en  = 1'b1;
				// Store data comes from rt
				ctrl_o.rt_en  = (inst_i.i.op == OP_SW);
				ctrl_o.wreg   = (inst_i.i.op == OP_LW);
				ctrl_o.wd     = inst_i.i.rt;
				ctrl_o.imm    = imm_sext;
			end
			default: begin
				if (i_known) begin
					ctrl_o.aluop  = i_op;
					ctrl_o.alusel = i_sel;
					ctrl_o.imm    = i_imm;
					// LUI reads no register, both operands carry the immediate
					ctrl_o.rs_en  = (inst_i.i.op != OP_LUI);
					ctrl_o.wreg   = 1'b1;
					ctrl_o.wd     = inst_i.i.rt;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

/* source/operand_fwd.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_fwd (
	input  mips_id_pkg::reg_idx_t    idx_i,
	input  logic                     en_i,
	input  mips_id_pkg::word_t       imm_i,
	input  mips_id_pkg::word_t       rf_data_i,
	input  mips_id_pkg::ex_bypass_t  ex_i,
	input  mips_id_pkg::mem_bypass_t mem_i,
	output mips_id_pkg::word_t       operand_o,
	output logic                     hazard_o
);

	logic idx_nz;
	logic ex_hit;
	logic mem_hit;

	// r0 never forwards
	assign idx_nz  = (idx_i != 5'd0);
	assign ex_hit  = en_i && idx_nz && ex_i.wreg && (ex_i.wd == idx_i);
	assign mem_hit = en_i && idx_nz && mem_i.wreg && (mem_i.wd == idx_i);

	always_comb begin
		if (!en_i) begin
			operand_o = imm_i;
		end else if (ex_hit) begin
			operand_o = ex_i.wdata;
		end else if (mem_hit) begin
			operand_o = mem_i.wdata;
		end else begin
			operand_o = rf_data_i;
		end
	end

	// Load data not ready until MEM
	assign hazard_o = en_i && idx_nz && ex_i.is_load && (ex_i.wd == idx_i);

endmodule

`default_nettype wire

/* source/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
	input  mips_id_pkg::word_t     pc_i,
	input  mips_id_pkg::dec_ctrl_t ctrl_i,
	input  mips_id_pkg::word_t     op1_i,
	input  mips_id_pkg::word_t     op2_i,
	output mips_id_pkg::redirect_t redirect_o,
	output mips_id_pkg::word_t     link_addr_o
);
	import mips_id_pkg::*;

	word_t pc_plus4;
	word_t pc_plus8;
	word_t br_target;

	assign pc_plus4  = pc_i + 32'd4;
	assign pc_plus8  = pc_i + 32'd8;
	assign br_target = pc_plus4 + {ctrl_i.imm[29:0], 2'b00};

	always_comb begin
		redirect_o = '0;
		case (ctrl_i.br_kind)
			BR_JUMP: begin
				redirect_o.taken  = 1'b1;
				// J and JAL carry the full target in imm
				redirect_o.target = (ctrl_i.aluop == ALU_JR) ? op1_i : ctrl_i.imm;
			end
			BR_EQ: begin
				redirect_o.taken  = (op1_i == op2_i);
				redirect_o.target = br_target;
			end
			BR_NE: begin
				redirect_o.taken  = (op1_i != op2_i);
				redirect_o.target = br_target;
			end
			default: begin
			end
		endcase
	end

	// Return past the delay slot
	assign link_addr_o = ctrl_i.link ? pc_plus8 : '0;

endmodule

`default_nettype wire

/* source/id_ex_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_fifo #(
	parameter int DEPTH = 2
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                push_i,
	input  mips_id_pkg::id_ex_t data_i,
	output logic                full_o,
	output logic                valid_o,
	output mips_id_pkg::id_ex_t data_o,
	input  logic                ready_i
);
	import mips_id_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	id_ex_t             slots [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   count;
	logic               pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == PTR_W'(DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign pop     = valid_o && ready_i;
	assign valid_o = (count != '0);
	assign full_o  = (count == CNT_W'(DEPTH));
	assign data_o  = slots[rd_ptr];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push_i, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (push_i) begin
			slots[wr_ptr] <= data_i;
		end
	end

	a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
		!(push_i && full_o && !pop));

endmodule

`default_nettype wire

/* source/id_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage #(
	parameter int OUT_DEPTH = 2
) (
	input  logic                     clk_i,
	input  logic                     rst_i,
	input  logic                     in_valid_i,
	input  mips_id_pkg::fetch_t      in_i,
	output logic                     in_ready_o,
	input  mips_id_pkg::ex_bypass_t  ex_i,
	input  mips_id_pkg::mem_bypass_t mem_i,
	input  mips_id_pkg::wb_t         wb_i,
	output mips_id_pkg::redirect_t   redirect_o,
	output logic                     out_valid_o,
	output mips_id_pkg::id_ex_t      out_o,
	input  logic                     out_ready_i
);
	import mips_id_pkg::*;

	dec_ctrl_t ctrl;
	word_t     rf_rdata1;
	word_t     rf_rdata2;
	word_t     reg1;
	word_t     reg2;
	word_t     link_addr;
	logic      hazard1;
	logic      hazard2;
	logic      fifo_full;
	logic      accept;
	redirect_t br_redirect;
	id_ex_t    dec_op;

	assign in_ready_o = !(hazard1 || hazard2 || fifo_full);
	assign accept     = in_valid_i && in_ready_o;
	// Only an accepted instruction may steer fetch
	assign redirect_o = '{taken: br_redirect.taken && accept, target: br_redirect.target};

	assign dec_op = '{
		aluop:      ctrl.aluop,
		alusel:     ctrl.alusel,
		reg1:       reg1,
		reg2:       reg2,
		wd:         ctrl.wd,
		wreg:       ctrl.wreg,
		link_addr:  link_addr,
		mem_offset: (ctrl.alusel == SEL_LOAD_STORE) ? ctrl.imm : '0
	};

	inst_decoder inst_decoder_inst (
		.inst_i (in_i.inst),
		.pc_i   (in_i.pc),
		.ctrl_o (ctrl)
	);

	reg_file reg_file_inst (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.wb_i     (wb_i),
		.raddr1_i (ctrl.rs),
		.raddr2_i (ctrl.rt),
		.rdata1_o (rf_rdata1),
		.rdata2_o (rf_rdata2)
	);

	operand_fwd fwd_rs_inst (
		.idx_i     (ctrl.rs),
		.en_i      (ctrl.rs_en),
		.imm_i     (ctrl.imm),
		.rf_data_i (rf_rdata1),
		.ex_i      (ex_i),
		.mem_i     (mem_i),
		.operand_o (reg1),
		.hazard_o  (hazard1)
	);

	operand_fwd fwd_rt_inst (
		.idx_i     (ctrl.rt),
		.en_i      (ctrl.rt_en),
		.imm_i     (ctrl.imm),
		.rf_data_i (rf_rdata2),
		.ex_i      (ex_i),
		.mem_i     (mem_i),
		.operand_o (reg2),
		.hazard_o  (hazard2)
	);

	branch_unit branch_unit_inst (
		.pc_i        (in_i.pc),
		.ctrl_i      (ctrl),
		.op1_i       (reg1),
		.op2_i       (reg2),
		.redirect_o  (br_redirect),
		.link_addr_o (link_addr)
	);

	id_ex_fifo #(
		.DEPTH (OUT_DEPTH)
	) id_ex_fifo_inst (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.push_i  (accept),
		.data_i  (dec_op),
		.full_o  (fifo_full),
		.valid_o (out_valid_o),
		.data_o  (out_o),
		.ready_i (out_ready_i)
	);

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS  = 40,
	parameter int RST_CYCLES = 5
) (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* tests/id_stage_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;
	import mips_id_pkg::*;

	localparam int NUM_VEC        = 20;
	localparam int TIMEOUT_CYCLES = 20 * NUM_VEC + 200;

	typedef struct packed {
		word_t       inst;
		word_t       pc;
		ex_bypass_t  ex;
		mem_bypass_t mem;
		logic        stall;
		logic [1:0]  chk_ops;
		word_t       reg1;
		word_t       reg2;
		reg_idx_t    wd;
		logic        wreg;
		alu_op_e     aluop;
		word_t       mem_off;
		logic        taken;
		word_t       target;
		word_t       link;
	} vec_t;

	logic        clk;
	logic        rst;
	logic        in_valid;
	fetch_t      in_data;
	logic        in_ready;
	ex_bypass_t  ex_byp;
	mem_bypass_t mem_byp;
	wb_t         wb;
	redirect_t   redirect;
	logic        out_valid;
	id_ex_t      out_data;
	logic        out_ready;

	word_t       model_regs [32];
	vec_t        vecs [NUM_VEC];
	int          cycle_count = 0;

	tb_clock_gen #(
		.PERIOD_NS  (40),
		.RST_CYCLES (5)
	) clock_gen_inst (
		.clk_o (clk),
		.rst_o (rst)
	);

	id_stage #(
		.OUT_DEPTH (2)
	) id_stage_inst (
		.clk_i       (clk),
		.rst_i       (rst),
		.in_valid_i  (in_valid),
		.in_i        (in_data),
		.in_ready_o  (in_ready),
		.ex_i        (ex_byp),
		.mem_i       (mem_byp),
		.wb_i        (wb),
		.redirect_o  (redirect),
		.out_valid_o (out_valid),
		.out_o       (out_data),
		.out_ready_i (out_ready)
	);

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Test failures found");
			$fatal(1, "Timed out waiting for the DUT after %0d cycles", cycle_count);
		end
	end

	////////////////////////////////////////////////////////////
	// Instruction encoding and expected-value helpers
	function automatic word_t r_type_word(input logic [5:0] funct, input reg_idx_t rs,
			input reg_idx_t rt, input reg_idx_t rd);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word_t i_type_word(input logic [5:0] op, input reg_idx_t rs,
			input reg_idx_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_type_word(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	function automatic word_t sext16(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic word_t branch_dest(input word_t pc, input logic [15:0] offset);
		return pc + 32'd4 + (sext16(offset) << 2);
	endfunction

	// Region bits come from the delay slot address
	function automatic word_t jump_dest(input word_t pc, input logic [25:0] target);
		word_t seq;
		seq = pc + 32'd4;
		return {seq[31:28], target, 2'b00};
	endfunction

	// Result class follows from the operation
	function automatic alu_sel_e expected_class(input alu_op_e op);
		alu_sel_e sel;
		case (op)
			ALU_OR, ALU_AND, ALU_XOR, ALU_NOR:        sel = SEL_LOGIC;
			ALU_ADDU, ALU_SUBU, ALU_SLT:              sel = SEL_ARITH;
			ALU_LW, ALU_SW:                           sel = SEL_LOAD_STORE;
			ALU_J, ALU_JAL, ALU_JR, ALU_BEQ, ALU_BNE: sel = SEL_JUMP_BRANCH;
			default:                                  sel = SEL_NOP;
		endcase
		return sel;
	endfunction

	function automatic vec_t blank_vec(input word_t inst, input word_t pc);
		vec_t v;
		v      = '0;
		v.inst = inst;
		v.pc   = pc;
		return v;
	endfunction

	function automatic vec_t with_result(input vec_t v, input logic [1:0] chk, input word_t r1,
			input word_t r2, input reg_idx_t wd, input logic wreg, input alu_op_e op);
		vec_t o;
		o         = v;
		o.chk_ops = chk;
		o.reg1    = r1;
		o.reg2    = r2;
		o.wd      = wd;
		o.wreg    = wreg;
		o.aluop   = op;
		return o;
	endfunction

	function automatic vec_t with_redirect(input vec_t v, input logic taken, input word_t target,
			input word_t link);
		vec_t o;
		o        = v;
		o.taken  = taken;
		o.target = target;
		o.link   = link;
		return o;
	endfunction

	task automatic check_value(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("ERROR %s: got 0x%08h, expected 0x%08h", name, actual, expected);
			$display("Test failures found");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus
	task automatic preload_regs();
		model_regs[0] = '0;
		for (int i = 1; i < 32; i++) begin
			@(negedge clk);
			model_regs[i] = $urandom();
			wb = '{we: 1'b1, waddr: reg_idx_t'(i), wdata: model_regs[i]};
		end
		@(negedge clk);
		wb = '0;
	endtask

	task automatic build_table();
		vec_t  v;
		word_t pc;
		vecs[0] = with_result(blank_vec(r_type_word(6'h25, 5'd1, 5'd2, 5'd3), 32'h0040_0000),
			2'b11, model_regs[1], model_regs[2], 5'd3, 1'b1, ALU_OR);
		vecs[1] = with_result(blank_vec(i_type_word(6'h0c, 5'd5, 5'd4, 16'h8f0f), 32'h0040_0004),
			2'b11, model_regs[5], 32'h0000_8f0f, 5'd4, 1'b1, ALU_AND);
		// Only the shifted immediate matters for LUI
		vecs[2] = with_result(blank_vec(i_type_word(6'h0f, 5'd0, 5'd6, 16'hbeef), 32'h0040_0008),
			2'b10, '0, 32'hbeef_0000, 5'd6, 1'b1, ALU_OR);
		vecs[3] = with_result(blank_vec(i_type_word(6'h09, 5'd8, 5'd7, 16'hfffc), 32'h0040_000c),
			2'b11, model_regs[8], 32'hffff_fffc, 5'd7, 1'b1, ALU_ADDU);
		vecs[4] = with_result(blank_vec(i_type_word(6'h0a, 5'd10, 5'd9, 16'h7ff0), 32'h0040_0010),
			2'b11, model_regs[10], 32'h0000_7ff0, 5'd9, 1'b1, ALU_SLT);
		vecs[5] = with_result(blank_vec(r_type_word(6'h23, 5'd12, 5'd13, 5'd11), 32'h0040_0014),
			2'b11, model_regs[12], model_regs[13], 5'd11, 1'b1, ALU_SUBU);
		vecs[6] = with_result(blank_vec(i_type_word(6'h3f, 5'd1, 5'd2, 16'h1234), 32'h0040_0018),
			2'b00, '0, '0, 5'd0, 1'b0, ALU_NOP);

		// Forwarding priority
		v = with_result(blank_vec(r_type_word(6'h25, 5'd15, 5'd16, 5'd14), 32'h0040_001c),
			2'b11, 32'ha5a5_0001, model_regs[16], 5'd14, 1'b1, ALU_OR);
		v.ex  = '{wreg: 1'b1, is_load: 1'b0, wd: 5'd15, wdata: 32'ha5a5_0001};
		v.mem = '{wreg: 1'b1, wd: 5'd15, wdata: 32'h5a5a_0002};
		vecs[7] = v;
		v = with_result(blank_vec(r_type_word(6'h23, 5'd18, 5'd19, 5'd17), 32'h0040_0020),
			2'b11, model_regs[18], 32'h3333_4444, 5'd17, 1'b1, ALU_SUBU);
		v.ex  = '{wreg: 1'b1, is_load: 1'b0, wd: 5'd20, wdata: 32'h1111_2222};
		v.mem = '{wreg: 1'b1, wd: 5'd19, wdata: 32'h3333_4444};
		vecs[8] = v;
		v = with_result(blank_vec(r_type_word(6'h25, 5'd0, 5'd21, 5'd20), 32'h0040_0024),
			2'b11, '0, model_regs[21], 5'd20, 1'b1, ALU_OR);
		v.ex  = '{wreg: 1'b1, is_load: 1'b0, wd: 5'd0, wdata: 32'hdead_beef};
		v.mem = '{wreg: 1'b1, wd: 5'd0, wdata: 32'h1234_5678};
		vecs[9] = v;

		// Load in EX targets rs
		v = with_result(blank_vec(r_type_word(6'h21, 5'd23, 5'd24, 5'd22), 32'h0040_0028),
			2'b11, model_regs[23], model_regs[24], 5'd22, 1'b1, ALU_ADDU);
		v.ex    = '{wreg: 1'b1, is_load: 1'b1, wd: 5'd23, wdata: 32'hbad0_0bad};
		v.stall = 1'b1;
		vecs[10] = v;

		pc = 32'h0040_1000;
		v = with_result(blank_vec(i_type_word(6'h04, 5'd1, 5'd1, 16'h0005), pc),
			2'b11, model_regs[1], model_regs[1], 5'd0, 1'b0, ALU_BEQ);
		vecs[11] = with_redirect(v, 1'b1, branch_dest(pc, 16'h0005), '0);
		pc = 32'h0040_2000;
		v = with_result(blank_vec(i_type_word(6'h04, 5'd1, 5'd2, 16'hfffd), pc),
			2'b11, model_regs[1], model_regs[2], 5'd0, 1'b0, ALU_BEQ);
		vecs[12] = with_redirect(v, model_regs[1] == model_regs[2], branch_dest(pc, 16'hfffd), '0);
		pc = 32'h0040_3000;
		v = with_result(blank_vec(i_type_word(6'h05, 5'd4, 5'd5, 16'h0010), pc),
			2'b11, model_regs[4], model_regs[5], 5'd0, 1'b0, ALU_BNE);
		vecs[13] = with_redirect(v, model_regs[4] != model_regs[5], branch_dest(pc, 16'h0010), '0);
		pc = 32'h0040_3100;
		v = with_result(blank_vec(i_type_word(6'h05, 5'd6, 5'd6, 16'h0020), pc),
			2'b11, model_regs[6], model_regs[6], 5'd0, 1'b0, ALU_BNE);
		vecs[14] = with_redirect(v, 1'b0, branch_dest(pc, 16'h0020), '0);

		// pc+4 crosses into the next region
		pc = 32'h1fff_fffc;
		v = with_result(blank_vec(j_type_word(6'h02, 26'h012_3456), pc),
			2'b00, '0, '0, 5'd0, 1'b0, ALU_J);
		vecs[15] = with_redirect(v, 1'b1, jump_dest(pc, 26'h012_3456), '0);
		v = with_result(blank_vec(r_type_word(6'h08, 5'd25, 5'd0, 5'd0), 32'h0040_4000),
			2'b01, model_regs[25], '0, 5'd0, 1'b0, ALU_JR);
		vecs[16] = with_redirect(v, 1'b1, model_regs[25], '0);
		pc = 32'h2000_0100;
		v = with_result(blank_vec(j_type_word(6'h03, 26'h2ab_cdef), pc),
			2'b00, '0, '0, 5'd31, 1'b1, ALU_JAL);
		vecs[17] = with_redirect(v, 1'b1, jump_dest(pc, 26'h2ab_cdef), pc + 32'd8);

		vecs[18] = with_result(blank_vec(i_type_word(6'h23, 5'd27, 5'd26, 16'hfff8),
			32'h0040_5000), 2'b01, model_regs[27], '0, 5'd26, 1'b1, ALU_LW);
		vecs[18].mem_off = sext16(16'hfff8);
		vecs[19] = with_result(blank_vec(i_type_word(6'h2b, 5'd29, 5'd28, 16'h000c),
			32'h0040_5004), 2'b11, model_regs[29], model_regs[28], 5'd0, 1'b0, ALU_SW);
		vecs[19].mem_off = sext16(16'h000c);
	endtask

	task automatic wait_output();
		while (!out_valid) begin
			@(negedge clk);
			#1;
		end
	endtask

	task automatic expect_output(input vec_t v);
		check_value("out_o.aluop", 32'(out_data.aluop), 32'(v.aluop));
		check_value("out_o.alusel", 32'(out_data.alusel), 32'(expected_class(v.aluop)));
		check_value("out_o.wreg", 32'(out_data.wreg), 32'(v.wreg));
		if (v.wreg) begin
			check_value("out_o.wd", 32'(out_data.wd), 32'(v.wd));
		end
		if (v.chk_ops[0]) begin
			check_value("out_o.reg1", out_data.reg1, v.reg1);
		end
		if (v.chk_ops[1]) begin
			check_value("out_o.reg2", out_data.reg2, v.reg2);
		end
		check_value("out_o.link_addr", out_data.link_addr, v.link);
		check_value("out_o.mem_offset", out_data.mem_offset, v.mem_off);
	endtask

	task automatic run_vector(input vec_t v);
		@(negedge clk);
		in_data.pc   = v.pc;
		in_data.inst = v.inst;
		in_valid     = 1'b1;
		ex_byp       = v.ex;
		mem_byp      = v.mem;
		out_ready    = 1'b1;
		if (v.stall) begin
			for (int k = 0; k < 3; k++) begin
				#1;
				check_value("in_ready_o", 32'(in_ready), 32'd0);
				check_value("redirect_o.taken", 32'(redirect.taken), 32'd0);
				check_value("out_valid_o", 32'(out_valid), 32'd0);
				@(negedge clk);
			end
			ex_byp = '0;
		end
		#1;
		check_value("in_ready_o", 32'(in_ready), 32'd1);
		check_value("redirect_o.taken", 32'(redirect.taken), 32'(v.taken));
		if (v.taken) begin
			check_value("redirect_o.target", redirect.target, v.target);
		end
		@(negedge clk);
		in_valid = 1'b0;
		ex_byp   = '0;
		mem_byp  = '0;
		#1;
		wait_output();
		expect_output(v);
	endtask

	// Two entries fill the queue and hold off a third
	task automatic run_backpressure();
		@(negedge clk);
		out_ready    = 1'b0;
		in_valid     = 1'b1;
		in_data.pc   = vecs[0].pc;
		in_data.inst = vecs[0].inst;
		#1;
		check_value("in_ready_o", 32'(in_ready), 32'd1);
		@(negedge clk);
		in_data.pc   = vecs[5].pc;
		in_data.inst = vecs[5].inst;
		#1;
		check_value("in_ready_o", 32'(in_ready), 32'd1);
		check_value("out_valid_o", 32'(out_valid), 32'd1);
		@(negedge clk);
		in_data.pc   = vecs[1].pc;
		in_data.inst = vecs[1].inst;
		for (int k = 0; k < 3; k++) begin
			#1;
			check_value("in_ready_o", 32'(in_ready), 32'd0);
			check_value("out_valid_o", 32'(out_valid), 32'd1);
			@(negedge clk);
		end
		in_valid  = 1'b0;
		out_ready = 1'b1;
		#1;
		expect_output(vecs[0]);
		@(negedge clk);
		#1;
		expect_output(vecs[5]);
		@(negedge clk);
		#1;
		check_value("out_valid_o", 32'(out_valid), 32'd0);
		check_value("in_ready_o", 32'(in_ready), 32'd1);
	endtask

	////////////////////////////////////////////////////////////
	initial begin
		void'($urandom(66));
		in_valid  = 1'b0;
		in_data   = '0;
		ex_byp    = '0;
		mem_byp   = '0;
		wb        = '0;
		out_ready = 1'b0;

		@(negedge clk);
		while (rst) begin
			@(negedge clk);
		end
		#1;
		check_value("out_valid_o", 32'(out_valid), 32'd0);
		check_value("redirect_o.taken", 32'(redirect.taken), 32'd0);
		check_value("in_ready_o", 32'(in_ready), 32'd1);

		preload_regs();
		build_table();
		for (int n = 0; n < NUM_VEC; n++) begin
			run_vector(vecs[n]);
		end
		run_backpressure();

		@(negedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
source/mips_id_pkg.sv
source/reg_file.sv
source/inst_decoder.sv
source/operand_fwd.sv
source/branch_unit.sv
source/id_ex_fifo.sv
source/id_stage.sv
tests/tb_clock_gen.sv
tests/id_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module id_stage_tb -f flist.f -o sim_id_stage &&
./obj_dir/sim_id_stage ||
{ echo "Simulation did not pass"; exit 1; }
